// File: bchPkg.sv
`default_nettype none

package bchPkg;

	// Code geometry --------------------------------------
	localparam int codeLength = 15;
	localparam int messageLength = 5;
	localparam int parityLength = codeLength - messageLength;
	localparam logic [parityLength:0] generatorPoly = 11'h537; // x^10+x^8+x^5+x^4+x^2+x+1
	localparam int maxLimit = 3; // Half of dmin 7, rounded down

	// Data types -----------------------------------------
	typedef logic [messageLength-1:0] message;

	typedef struct packed {
		logic [messageLength-1:0] message; // Systematic part on top
		logic [parityLength-1:0] parity;
	} codeFields;

	typedef union packed {
		logic [codeLength-1:0] raw;
		codeFields fields;
	} codeWord;

	typedef struct packed {
		logic [messageLength-1:0] message;
		logic [codeLength-1:0] errorMask;
	} frameIn;

	typedef struct packed {
		codeWord received;
		message sent; // Tag for the monitor
	} channelFrame;

	typedef struct packed {
		message decoded;
		message sent;
		logic uncorrectable;
		logic [1:0] distance; // Corrected bits
	} decodeResult;

	// Helpers --------------------------------------------
	function automatic logic [parityLength-1:0] computeParity(input message msg);
		logic [parityLength-1:0] rem;
		logic feedback;
		rem = '0;
		for (int i = messageLength - 1; i >= 0; i--) begin
			feedback = msg[i] ^ rem[parityLength-1];
			rem = {rem[parityLength-2:0], 1'b0};
			if (feedback) begin
				rem = rem ^ generatorPoly[parityLength-1:0];
			end
		end
		return rem;
	endfunction

	function automatic logic [3:0] hammingWeight(input logic [codeLength-1:0] word);
		logic [3:0] count;
		count = '0;
		for (int i = 0; i < codeLength; i++) begin
			count = count + {3'b000, word[i]};
		end
		return count;
	endfunction

endpackage

`default_nettype wire

// File: bchEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module bchEncoder (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input bchPkg::frameIn inFrame,
	output logic chanValid,
	input logic chanReady,
	output bchPkg::channelFrame chanFrame
);
	import bchPkg::*;

	frameIn frameReg;
	logic [messageLength-1:0] msgShift;
	logic [parityLength-1:0] remainder;
	logic [parityLength-1:0] nextRemainder;
	logic [2:0] bitCount;
	logic shifting;
	logic lastBit;
	logic feedback;
	logic accept;
	codeWord cleanWord;
	codeWord sendWord;

	assign accept = inValid && inReady;
	assign lastBit = shifting && (bitCount == 3'(messageLength - 1));

	// Division LFSR ---------------------------------------
	assign feedback = msgShift[messageLength-1] ^ remainder[parityLength-1];

	always_comb begin
		nextRemainder = {remainder[parityLength-2:0], 1'b0};
		if (feedback) begin
			nextRemainder = nextRemainder ^ generatorPoly[parityLength-1:0];
		end
	end

	always_comb begin
		cleanWord.fields.message = frameReg.message;
		cleanWord.fields.parity = nextRemainder; // Remainder after the last shift
		sendWord.raw = cleanWord.raw ^ frameReg.errorMask; // Channel errors
	end

	// Control ---------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			inReady <= 1'b0;
			shifting <= 1'b0;
			chanValid <= 1'b0;
		end else begin
			if (accept) begin
				inReady <= 1'b0;
				shifting <= 1'b1;
			end else if (!shifting && !chanValid) begin
				inReady <= 1'b1; // Idle
			end
			if (lastBit) begin
				shifting <= 1'b0;
				chanValid <= 1'b1;
			end
			if (chanValid && chanReady) begin
				chanValid <= 1'b0;
				inReady <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			frameReg <= inFrame;
			msgShift <= inFrame.message;
			remainder <= '0;
			bitCount <= '0;
		end else if (shifting) begin
			msgShift <= {msgShift[messageLength-2:0], 1'b0}; // MSB first
			remainder <= nextRemainder;
			bitCount <= bitCount + 3'd1;
		end
		if (lastBit) begin
			chanFrame.received <= sendWord;
			chanFrame.sent <= frameReg.message;
		end
	end

	// Held frame must not change until the decoder takes it
	assert property (@(posedge clk) disable iff (reset)
		chanValid && !chanReady |=> chanValid && $stable(chanFrame))
		else $error("chanFrame changed while waiting for chanReady");

	// Serial remainder agrees with the closed form, mask removed
	assert property (@(posedge clk) disable iff (reset)
		chanValid |-> ((chanFrame.received.raw ^ frameReg.errorMask) & {parityLength{1'b1}})
			== {5'b00000, computeParity(chanFrame.sent)})
		else $error("Encoder parity differs from computeParity");

endmodule

`default_nettype wire

// File: bchDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module bchDecoder #(
	parameter int limit = 3
) (
	input logic clk,
	input logic reset,
	input logic chanValid,
	output logic chanReady,
	input bchPkg::channelFrame chanFrame,
	output logic decValid,
	output bchPkg::decodeResult decResult
);
	import bchPkg::*;

	logic busy;
	logic accept;
	logic lastCand;
	logic [messageLength-1:0] candidate;
	codeWord received;
	message sentReg;
	codeWord candWord;
	logic [3:0] candDist;
	logic [3:0] bestDist;
	message bestMsg;
	logic [3:0] finalDist;
	message finalMsg;

	assign accept = chanValid && chanReady;
	assign lastCand = busy && (candidate == '1);

	// Candidate evaluation --------------------------------
	always_comb begin
		candWord.fields.message = candidate;
		candWord.fields.parity = computeParity(candidate);
		candDist = hammingWeight(candWord.raw ^ received.raw);
	end

	// Running minimum with the first candidate always taken
	always_comb begin
		if (candidate == '0 || candDist < bestDist) begin
			finalDist = candDist;
			finalMsg = candidate;
		end else begin
			finalDist = bestDist;
			finalMsg = bestMsg;
		end
	end

	// Control ---------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			chanReady <= 1'b0;
			decValid <= 1'b0;
		end else begin
			decValid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				chanReady <= 1'b0;
			end else if (lastCand) begin
				busy <= 1'b0;
				chanReady <= 1'b1; // Ready again with the result
				decValid <= 1'b1;
			end else if (!busy) begin
				chanReady <= 1'b1;
			end
		end
	end

	// Search datapath -------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			received <= chanFrame.received;
			sentReg <= chanFrame.sent;
			candidate <= '0;
		end else if (busy) begin
			candidate <= candidate + 1'b1; // Wraps to zero after the last one
			bestDist <= finalDist;
			bestMsg <= finalMsg;
		end
	end

	always_ff @(posedge clk) begin
		if (lastCand) begin
			decResult.decoded <= finalMsg;
			decResult.sent <= sentReg;
			decResult.uncorrectable <= finalDist > 4'(limit);
			decResult.distance <= finalDist[1:0]; // Only meaningful when correctable
		end
	end

	// Checks ----------------------------------------------
	assert property (@(posedge clk) disable iff (reset) limit <= maxLimit)
		else $error("Correction limit %0d above %0d", limit, maxLimit);

	// Encoder must be held off for the whole search
	assert property (@(posedge clk) disable iff (reset) busy |-> !accept)
		else $error("Frame accepted during a search");

endmodule

`default_nettype wire

// File: frameMonitor.sv
`timescale 1ns/100ps
`default_nettype none

module frameMonitor (
	input logic clk,
	input logic reset,
	input logic decValid,
	input bchPkg::decodeResult decResult,
	output logic outValid,
	output bchPkg::decodeResult outResult,
	output logic wrongNow,
	output logic wrong,
	output logic [15:0] frameCount,
	output logic [15:0] wrongCount
);
	import bchPkg::*;

	logic mismatch;

	// Miscorrection when claimed correctable but not the sent message
	assign mismatch = decValid && !decResult.uncorrectable
		&& (decResult.decoded != decResult.sent);

	// Flags and counters ----------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			wrongNow <= 1'b0;
			wrong <= 1'b0;
			frameCount <= '0;
			wrongCount <= '0;
		end else begin
			outValid <= decValid;
			wrongNow <= mismatch;
			if (mismatch) begin
				wrong <= 1'b1; // Sticky
				wrongCount <= wrongCount + 16'd1;
			end
			if (decValid) begin
				frameCount <= frameCount + 16'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			outResult <= decResult;
		end
	end

	// Sticky flag only clears through reset
	assert property (@(posedge clk) disable iff (reset) wrong |=> wrong)
		else $error("wrong fell outside reset");

endmodule

`default_nettype wire

// File: bchLoopback.sv
`timescale 1ns/100ps
`default_nettype none

module bchLoopback #(
	parameter int limit = 3
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input bchPkg::frameIn inFrame,
	output logic outValid,
	output bchPkg::decodeResult outResult,
	output logic wrongNow,
	output logic wrong,
	output logic [15:0] frameCount,
	output logic [15:0] wrongCount
);
	import bchPkg::*;

	// Encoder to decoder
	logic chanValid;
	logic chanReady;
	channelFrame chanFrame;

	// Decoder to monitor, no back-pressure
	logic decValid;
	decodeResult decResult;

	// Input side ------------------------------------------
	bchEncoder encoder (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inFrame(inFrame),
		.chanValid(chanValid),
		.chanReady(chanReady),
		.chanFrame(chanFrame)
	);

	// Nearest-codeword search -----------------------------
	bchDecoder #(
		.limit(limit)
	) decoder (
		.clk(clk),
		.reset(reset),
		.chanValid(chanValid),
		.chanReady(chanReady),
		.chanFrame(chanFrame),
		.decValid(decValid),
		.decResult(decResult)
	);

	// Output side -----------------------------------------
	frameMonitor monitor (
		.clk(clk),
		.reset(reset),
		.decValid(decValid),
		.decResult(decResult),
		.outValid(outValid),
		.outResult(outResult),
		.wrongNow(wrongNow),
		.wrong(wrong),
		.frameCount(frameCount),
		.wrongCount(wrongCount)
	);

endmodule

`default_nettype wire

// File: bchLoopbackTb.sv
`timescale 1ns/100ps
`default_nettype none

module bchLoopbackTb;
	import bchPkg::*;

	localparam int frameTotal = 60;
	localparam int timeoutCycles = frameTotal * 45 + 100;
	localparam int idleLatency = 39; // Input transfer to outValid, decoder free
	localparam int searchSpacing = 33; // Decoder accept to next accept
	localparam int idleGap = 36; // Long enough to let the decoder drain

	typedef struct {
		message msg;
		int weight;
		int acceptEdge;
	} pending;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	frameIn inFrame;
	logic outValid;
	decodeResult outResult;
	logic wrongNow;
	logic wrong;
	logic [15:0] frameCount;
	logic [15:0] wrongCount;

	int sendWeight;
	int edgeIndex = 0;
	int acceptedCount = 0;
	int seenCount = 0;
	int pulseCount = 0;
	int lastOutEdge = 0;
	logic [31:0] lfsrState = 32'h9402d0fd;
	pending expectQ[$];

	bchLoopback #(
		.limit(3)
	) DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inFrame(inFrame),
		.outValid(outValid),
		.outResult(outResult),
		.wrongNow(wrongNow),
		.wrong(wrong),
		.frameCount(frameCount),
		.wrongCount(wrongCount)
	);

	always #4 clk = ~clk;

	// Failure reporting -----------------------------
	task automatic endWithFailure();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic stopRun(input string reason);
		$display("%s at t=%0t", reason, $time);
		endWithFailure();
	endtask

	task automatic valueFail(input string name, input int expected, input int actual);
		$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
		endWithFailure();
	endtask

	// Stimulus source -------------------------------
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'hA3000000;
		end
		return state >> 1;
	endfunction

	function automatic int randomBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState); // One step per bit
		end
		return value;
	endfunction

	function automatic logic [codeLength-1:0] randomMask(input int weight);
		logic [codeLength-1:0] mask;
		int placed;
		int pos;
		mask = '0;
		placed = 0;
		while (placed < weight) begin
			pos = randomBits(4);
			if (pos < codeLength && !mask[pos]) begin
				mask[pos] = 1'b1;
				placed++;
			end
		end
		return mask;
	endfunction

	// Holds the frame until the DUT takes it
	task automatic sendFrame(input frameIn frame, input int weight);
		int target;
		target = acceptedCount + 1;
		inFrame = frame;
		sendWeight = weight;
		inValid = 1'b1;
		while (acceptedCount < target) begin
			@(negedge clk);
		end
		inValid = 1'b0;
	endtask

	// Edge count, input transfers, timeout
	always @(posedge clk) begin
		pending entry;
		edgeIndex = edgeIndex + 1;
		if (edgeIndex > timeoutCycles) begin
			stopRun("Timeout: not all frames came out within the cycle limit");
		end else if (inValid && inReady) begin
			entry.msg = inFrame.message;
			entry.weight = sendWeight;
			entry.acceptEdge = edgeIndex;
			expectQ.push_back(entry);
			acceptedCount++;
		end
	end

	// Output checks ---------------------------------
	always @(negedge clk) begin
		pending exp;
		int expectedEdge;
		if (!reset) begin
			if (!outValid) begin
				assert (!wrongNow) else valueFail("wrongNow", 0, wrongNow);
			end else if (expectQ.size() == 0) begin
				stopRun("outValid seen with no frame in flight");
			end else begin
				exp = expectQ.pop_front();
				seenCount++;
				expectedEdge = exp.acceptEdge + idleLatency;
				if (lastOutEdge + searchSpacing > expectedEdge) begin
					expectedEdge = lastOutEdge + searchSpacing; // Waited for the decoder
				end
				assert (edgeIndex == expectedEdge)
					else valueFail("outValid edge", expectedEdge, edgeIndex);
				lastOutEdge = edgeIndex;
				assert (outResult.sent == exp.msg)
					else valueFail("outResult.sent", exp.msg, outResult.sent);
				if (exp.weight <= 3) begin
					assert (!outResult.uncorrectable)
						else valueFail("outResult.uncorrectable", 0, outResult.uncorrectable);
					assert (outResult.decoded == exp.msg)
						else valueFail("outResult.decoded", exp.msg, outResult.decoded);
					assert (outResult.distance == exp.weight)
						else valueFail("outResult.distance", exp.weight, outResult.distance);
					assert (!wrongNow) else valueFail("wrongNow", 0, wrongNow);
				end else if (outResult.uncorrectable) begin
					assert (!wrongNow) else valueFail("wrongNow", 0, wrongNow);
				end else begin
					assert (outResult.decoded != exp.msg)
						else stopRun("Weight-4 frame decoded to the sent message");
					assert (wrongNow) else valueFail("wrongNow", 1, wrongNow);
				end
				if (wrongNow) begin
					pulseCount++;
				end
				assert (frameCount == seenCount)
					else valueFail("frameCount", seenCount, frameCount);
				assert (wrongCount == pulseCount)
					else valueFail("wrongCount", pulseCount, wrongCount);
				assert (wrong == (pulseCount > 0))
					else valueFail("wrong", pulseCount > 0, wrong);
			end
			// Encoder must hold off while a frame waits for the decoder
			assert (acceptedCount - seenCount <= 2)
				else stopRun("More than two frames in flight");
			if (acceptedCount - seenCount == 2) begin
				assert (!inReady) else valueFail("inReady", 0, inReady);
			end
		end
	end

	// Main sequence ---------------------------------
	initial begin
		frameIn frame;
		int weight;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inFrame = '0;
		sendWeight = 0;
		repeat (4) @(negedge clk);
		assert (!inReady) else valueFail("inReady", 0, inReady);
		assert (!outValid) else valueFail("outValid", 0, outValid);
		assert (!wrongNow) else valueFail("wrongNow", 0, wrongNow);
		assert (!wrong) else valueFail("wrong", 0, wrong);
		assert (frameCount == 0) else valueFail("frameCount", 0, frameCount);
		assert (wrongCount == 0) else valueFail("wrongCount", 0, wrongCount);
		reset = 1'b0;
		@(negedge clk);
		assert (inReady) else valueFail("inReady", 1, inReady);

		for (int i = 0; i < frameTotal; i++) begin
			weight = i % 5; // Even spread over weights 0 to 4
			frame.message = message'(randomBits(messageLength));
			frame.errorMask = randomMask(weight);
			sendFrame(frame, weight);
			if (randomBits(1) == 1) begin
				repeat (idleGap) @(negedge clk);
			end
		end

		while (seenCount < frameTotal) begin
			@(negedge clk);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bchLoopback.f
bchPkg.sv
bchEncoder.sv
bchDecoder.sv
frameMonitor.sv
bchLoopback.sv
bchLoopbackTb.sv

// File: Bender.yml
package:
  name: bchLoopback

sources:
  - bchPkg.sv
  - bchEncoder.sv
  - bchDecoder.sv
  - frameMonitor.sv
  - bchLoopback.sv
  - target: simulation
    files:
      - bchLoopbackTb.sv
